// ==== exec_config_pkg.sv ====
/*
  Execution core sizing
  Default depths for the reorder buffer and the multiply pipe,
  picked up by the top level as its parameter defaults
*/
package exec_config_pkg;

  // Reorder buffer slots, also the sender's starting credit count
  localparam int ROB_DEPTH_DEFAULT = 8;

  // Number of multiply stages
  localparam int MUL_LATENCY_DEFAULT = 3;

endpackage

// ==== uop_pkg.sv ====
/*
  Micro-op definitions
  Operand width, sender sequence id and the opcode set shared by
  the intake stage, both pipes and the reorder buffer
*/
package uop_pkg;

  // Operand and result word
  typedef logic [31:0] data_t;

  // Sequence id attached by the sender, returned unchanged at retire
  typedef logic [7:0] uop_id_t;

  typedef enum logic [2:0] {
    OP_ADD    = 3'd0,
    OP_SUB    = 3'd1,
    OP_XOR    = 3'd2,
    OP_MUL    = 3'd3,
    OP_STORE  = 3'd4,
    OP_BRANCH = 3'd5
  } op_kind_t;

endpackage

// ==== uop_intake.sv ====
/*
  Micro-op intake stage
  Takes one credit-covered micro-op per cycle, grabs a reorder buffer
  slot for it and issues it to the ALU or multiply pipe a cycle later
*/
`timescale 1ns/1ns

module uop_intake import uop_pkg::*; #(
  parameter int ROB_DEPTH = 8
) (
  input  logic                         clock,
  input  logic                         reset,
  input  logic                         in_valid,
  input  uop_id_t                      in_id,
  input  op_kind_t                     in_op,
  input  data_t                        in_src_a,
  input  data_t                        in_src_b,
  input  logic                         in_predict_taken,
  input  logic [$clog2(ROB_DEPTH)-1:0] alloc_tag,
  input  logic                         recover,
  output logic                         alloc,
  output uop_id_t                      alloc_id,
  output op_kind_t                     alloc_op,
  output logic                         alu_start,
  output logic                         mul_start,
  output logic [$clog2(ROB_DEPTH)-1:0] issue_tag,
  output op_kind_t                     issue_op,
  output data_t                        issue_src_a,
  output data_t                        issue_src_b,
  output logic                         issue_predict_taken
);

  logic accept;
  logic valid_q;

  // A micro-op arriving with recover is younger than the branch and is dropped
  assign accept   = in_valid && !recover;
  assign alloc    = accept;
  assign alloc_id = in_id;
  assign alloc_op = in_op;

  always_ff @(posedge clock) begin
    if (reset || recover) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= accept;
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      issue_tag           <= alloc_tag;
      issue_op            <= in_op;
      issue_src_a         <= in_src_a;
      issue_src_b         <= in_src_b;
      issue_predict_taken <= in_predict_taken;
    end
  end

  // Steer by opcode, multiplies go to their own pipe
  assign mul_start = valid_q && (issue_op == OP_MUL);
  assign alu_start = valid_q && (issue_op != OP_MUL);

endmodule

// ==== alu_pipe.sv ====
/*
  Single-cycle ALU pipe
  Add, sub, xor, store address generation and branch resolve,
  with the mispredict flag compared against the sender's prediction
*/
`timescale 1ns/1ns

module alu_pipe import uop_pkg::*; #(
  parameter int ROB_DEPTH = 8
) (
  input  logic                         clock,
  input  logic                         reset,
  input  logic                         recover,
  input  logic                         alu_start,
  input  logic [$clog2(ROB_DEPTH)-1:0] issue_tag,
  input  op_kind_t                     issue_op,
  input  data_t                        issue_src_a,
  input  data_t                        issue_src_b,
  input  logic                         issue_predict_taken,
  output logic                         alu_done,
  output logic [$clog2(ROB_DEPTH)-1:0] alu_done_tag,
  output data_t                        alu_done_result,
  output logic                         alu_mispredict
);

  data_t result_d;
  logic  branch_taken;

  assign branch_taken = (issue_src_a == issue_src_b);

  always_comb begin
    case (issue_op)
      OP_ADD:    result_d = issue_src_a + issue_src_b;
      OP_SUB:    result_d = issue_src_a - issue_src_b;
      OP_XOR:    result_d = issue_src_a ^ issue_src_b;
      OP_STORE:  result_d = issue_src_a + issue_src_b;   // base plus offset
      OP_BRANCH: result_d = data_t'(branch_taken);
      default:   result_d = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset || recover) begin
      alu_done <= 1'b0;
    end else begin
      alu_done <= alu_start;
    end
  end

  always_ff @(posedge clock) begin
    if (alu_start) begin
      alu_done_tag    <= issue_tag;
      alu_done_result <= result_d;
      alu_mispredict  <= (issue_op == OP_BRANCH) && (branch_taken != issue_predict_taken);
    end
  end

endmodule

// ==== mul_pipe.sv ====
/*
  Pipelined multiplier
  Splits the second operand into MUL_LATENCY chunks and adds one
  partial product per stage, keeping the low 32 bits of the product
*/
`timescale 1ns/1ns

module mul_pipe import uop_pkg::*; #(
  parameter int ROB_DEPTH   = 8,
  parameter int MUL_LATENCY = 3
) (
  input  logic                         clock,
  input  logic                         reset,
  input  logic                         recover,
  input  logic                         mul_start,
  input  logic [$clog2(ROB_DEPTH)-1:0] issue_tag,
  input  data_t                        issue_src_a,
  input  data_t                        issue_src_b,
  output logic                         mul_done,
  output logic [$clog2(ROB_DEPTH)-1:0] mul_done_tag,
  output data_t                        mul_done_result
);

  localparam int TAG_W   = $clog2(ROB_DEPTH);
  localparam int CHUNK_W = (32 + MUL_LATENCY - 1) / MUL_LATENCY;
  localparam int B_W     = CHUNK_W * MUL_LATENCY;

  typedef logic [TAG_W-1:0] tag_t;
  typedef logic [B_W-1:0]   wide_b_t;

  logic    valid_q [MUL_LATENCY];
  tag_t    tag_q   [MUL_LATENCY];
  data_t   acc_q   [MUL_LATENCY];
  data_t   a_q     [MUL_LATENCY];
  wide_b_t b_q     [MUL_LATENCY];
  wide_b_t src_b_wide;

  // Partial product of a with chunk s of b, already shifted into place
  function automatic data_t partial(data_t a, wide_b_t b, int s);
    logic [CHUNK_W-1:0] chunk;
    chunk = b[s*CHUNK_W +: CHUNK_W];
    return (a * data_t'(chunk)) << (s * CHUNK_W);
  endfunction

  assign src_b_wide = wide_b_t'(issue_src_b);

  always_ff @(posedge clock) begin
    if (reset || recover) begin
      for (int s = 0; s < MUL_LATENCY; s++) begin
        valid_q[s] <= 1'b0;
      end
    end else begin
      valid_q[0] <= mul_start;
      for (int s = 1; s < MUL_LATENCY; s++) begin
        valid_q[s] <= valid_q[s-1];
      end
    end
  end

  always_ff @(posedge clock) begin
    tag_q[0] <= issue_tag;
    a_q[0]   <= issue_src_a;
    b_q[0]   <= src_b_wide;
    acc_q[0] <= partial(issue_src_a, src_b_wide, 0);
    for (int s = 1; s < MUL_LATENCY; s++) begin
      tag_q[s] <= tag_q[s-1];
      a_q[s]   <= a_q[s-1];
      b_q[s]   <= b_q[s-1];
      acc_q[s] <= acc_q[s-1] + partial(a_q[s-1], b_q[s-1], s);
    end
  end

  assign mul_done        = valid_q[MUL_LATENCY-1];
  assign mul_done_tag    = tag_q[MUL_LATENCY-1];
  assign mul_done_result = acc_q[MUL_LATENCY-1];

endmodule

// ==== reorder_buffer.sv ====
/*
  Reorder buffer
  Circular table of in-flight micro-ops, written out of order by both
  pipes and retired in order from the head, with recover on mispredict
*/
`timescale 1ns/1ns

module reorder_buffer import uop_pkg::*; #(
  parameter int ROB_DEPTH = 8
) (
  input  logic                         clock,
  input  logic                         reset,
  input  logic                         alloc,
  input  uop_id_t                      alloc_id,
  input  op_kind_t                     alloc_op,
  input  logic                         alu_done,
  input  logic [$clog2(ROB_DEPTH)-1:0] alu_done_tag,
  input  data_t                        alu_done_result,
  input  logic                         alu_mispredict,
  input  logic                         mul_done,
  input  logic [$clog2(ROB_DEPTH)-1:0] mul_done_tag,
  input  data_t                        mul_done_result,
  output logic [$clog2(ROB_DEPTH)-1:0] alloc_tag,
  output logic                         retire_valid,
  output uop_id_t                      retire_id,
  output data_t                        retire_result,
  output logic                         store_retire,
  output logic                         recover,
  output logic                         credit_return
);

  localparam int TAG_W = $clog2(ROB_DEPTH);

  typedef logic [TAG_W-1:0] tag_t;

  typedef enum logic [1:0] {
    ENTRY_EMPTY,
    ENTRY_ISSUED,
    ENTRY_DONE
  } entry_state_t;

  entry_state_t state_q      [ROB_DEPTH];
  uop_id_t      id_q         [ROB_DEPTH];
  logic         store_q      [ROB_DEPTH];
  data_t        result_q     [ROB_DEPTH];
  logic         mispredict_q [ROB_DEPTH];

  tag_t head_q;
  tag_t tail_q;
  logic head_done;

  // Wraps explicitly so a depth that is not a power of two still works
  function automatic tag_t next_slot(tag_t slot);
    return (slot == tag_t'(ROB_DEPTH - 1)) ? '0 : slot + 1'b1;
  endfunction

  assign head_done = (state_q[head_q] == ENTRY_DONE);

  assign alloc_tag     = tail_q;
  assign retire_valid  = head_done;
  assign retire_id     = id_q[head_q];
  assign retire_result = result_q[head_q];
  assign store_retire  = head_done && store_q[head_q];
  assign recover       = head_done && mispredict_q[head_q];
  assign credit_return = head_done;

  // Credits keep tail off a live head, so alloc and retire never hit one slot
  always_ff @(posedge clock) begin
    if (reset || recover) begin
      head_q <= '0;
      tail_q <= '0;
      for (int i = 0; i < ROB_DEPTH; i++) begin
        state_q[i] <= ENTRY_EMPTY;
      end
    end else begin
      if (alloc) begin
        state_q[tail_q] <= ENTRY_ISSUED;
        tail_q          <= next_slot(tail_q);
      end
      if (alu_done) begin
        state_q[alu_done_tag] <= ENTRY_DONE;
      end
      if (mul_done) begin
        state_q[mul_done_tag] <= ENTRY_DONE;
      end
      if (head_done) begin
        state_q[head_q] <= ENTRY_EMPTY;
        head_q          <= next_slot(head_q);
      end
    end
  end

  // Entry payload, only meaningful while the state says so
  always_ff @(posedge clock) begin
    if (alloc) begin
      id_q[tail_q]    <= alloc_id;
      store_q[tail_q] <= (alloc_op == OP_STORE);
    end
    if (alu_done) begin
      result_q[alu_done_tag]     <= alu_done_result;
      mispredict_q[alu_done_tag] <= alu_mispredict;
    end
    if (mul_done) begin
      result_q[mul_done_tag]     <= mul_done_result;
      mispredict_q[mul_done_tag] <= 1'b0;
    end
  end

endmodule

// ==== retire_core.sv ====
/*
  Out-of-order execute and retire core
  Intake stage feeding an ALU pipe and a multiply pipe, with the
  reorder buffer putting results back in order
*/
`timescale 1ns/1ns

module retire_core import exec_config_pkg::*; import uop_pkg::*; #(
  parameter int ROB_DEPTH   = ROB_DEPTH_DEFAULT,
  parameter int MUL_LATENCY = MUL_LATENCY_DEFAULT
) (
  input  logic     clock,
  input  logic     reset,
  input  logic     in_valid,
  input  uop_id_t  in_id,
  input  op_kind_t in_op,
  input  data_t    in_src_a,
  input  data_t    in_src_b,
  input  logic     in_predict_taken,
  output logic     credit_return,
  output logic     retire_valid,
  output uop_id_t  retire_id,
  output data_t    retire_result,
  output logic     store_retire,
  output logic     recover
);

  localparam int TAG_W = $clog2(ROB_DEPTH);

  // Intake to reorder buffer
  logic             alloc;
  uop_id_t          alloc_id;
  op_kind_t         alloc_op;
  logic [TAG_W-1:0] alloc_tag;

  // Intake to both pipes
  logic             alu_start;
  logic             mul_start;
  logic [TAG_W-1:0] issue_tag;
  op_kind_t         issue_op;
  data_t            issue_src_a;
  data_t            issue_src_b;
  logic             issue_predict_taken;

  // Completions
  logic             alu_done;
  logic [TAG_W-1:0] alu_done_tag;
  data_t            alu_done_result;
  logic             alu_mispredict;
  logic             mul_done;
  logic [TAG_W-1:0] mul_done_tag;
  data_t            mul_done_result;

  uop_intake #(.ROB_DEPTH(ROB_DEPTH)) intake0 (
    .clock               (clock),
    .reset               (reset),
    .in_valid            (in_valid),
    .in_id               (in_id),
    .in_op               (in_op),
    .in_src_a            (in_src_a),
    .in_src_b            (in_src_b),
    .in_predict_taken    (in_predict_taken),
    .alloc_tag           (alloc_tag),
    .recover             (recover),
    .alloc               (alloc),
    .alloc_id            (alloc_id),
    .alloc_op            (alloc_op),
    .alu_start           (alu_start),
    .mul_start           (mul_start),
    .issue_tag           (issue_tag),
    .issue_op            (issue_op),
    .issue_src_a         (issue_src_a),
    .issue_src_b         (issue_src_b),
    .issue_predict_taken (issue_predict_taken)
  );

  alu_pipe #(.ROB_DEPTH(ROB_DEPTH)) alu0 (
    .clock               (clock),
    .reset               (reset),
    .recover             (recover),
    .alu_start           (alu_start),
    .issue_tag           (issue_tag),
    .issue_op            (issue_op),
    .issue_src_a         (issue_src_a),
    .issue_src_b         (issue_src_b),
    .issue_predict_taken (issue_predict_taken),
    .alu_done            (alu_done),
    .alu_done_tag        (alu_done_tag),
    .alu_done_result     (alu_done_result),
    .alu_mispredict      (alu_mispredict)
  );

  mul_pipe #(.ROB_DEPTH(ROB_DEPTH), .MUL_LATENCY(MUL_LATENCY)) mul0 (
    .clock           (clock),
    .reset           (reset),
    .recover         (recover),
    .mul_start       (mul_start),
    .issue_tag       (issue_tag),
    .issue_src_a     (issue_src_a),
    .issue_src_b     (issue_src_b),
    .mul_done        (mul_done),
    .mul_done_tag    (mul_done_tag),
    .mul_done_result (mul_done_result)
  );

  reorder_buffer #(.ROB_DEPTH(ROB_DEPTH)) rob0 (
    .clock           (clock),
    .reset           (reset),
    .alloc           (alloc),
    .alloc_id        (alloc_id),
    .alloc_op        (alloc_op),
    .alu_done        (alu_done),
    .alu_done_tag    (alu_done_tag),
    .alu_done_result (alu_done_result),
    .alu_mispredict  (alu_mispredict),
    .mul_done        (mul_done),
    .mul_done_tag    (mul_done_tag),
    .mul_done_result (mul_done_result),
    .alloc_tag       (alloc_tag),
    .retire_valid    (retire_valid),
    .retire_id       (retire_id),
    .retire_result   (retire_result),
    .store_retire    (store_retire),
    .recover         (recover),
    .credit_return   (credit_return)
  );

endmodule

// ==== retire_scoreboard.sv ====
/*
  Retire stream scoreboard
  Predicts the retire values of each accepted micro-op and checks
  the stream in order
*/
`timescale 1ns/1ns

module retire_scoreboard import uop_pkg::*; (
  input  logic     clock,
  input  logic     reset,
  input  logic     in_valid,
  input  uop_id_t  in_id,
  input  op_kind_t in_op,
  input  data_t    in_src_a,
  input  data_t    in_src_b,
  input  logic     in_predict_taken,
  input  logic     credit_return,
  input  logic     retire_valid,
  input  uop_id_t  retire_id,
  input  data_t    retire_result,
  input  logic     store_retire,
  input  logic     recover,
  output int       mismatches,
  output int       retired
);

  // Outstanding micro-ops in age order
  uop_id_t want_id      [$];
  data_t   want_result  [$];
  logic    want_store   [$];
  logic    want_recover [$];

  function automatic data_t expected_result(input op_kind_t op, input data_t a, input data_t b);
    case (op)
      OP_ADD:    return a + b;
      OP_SUB:    return a - b;
      OP_XOR:    return a ^ b;
      OP_MUL:    return a * b;
      OP_STORE:  return a + b;
      OP_BRANCH: return (a == b) ? 32'd1 : 32'd0;
      default:   return '0;
    endcase
  endfunction

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] want);
    if (got !== want) begin
      $display("FAILED %s: got %h expected %h at %0t", name, got, want, $time);
      mismatches++;
    end
  endtask

  always @(posedge clock) begin
    if (reset) begin
      mismatches = 0;
      retired    = 0;
      want_id.delete();
      want_result.delete();
      want_store.delete();
      want_recover.delete();
    end else begin
      if (credit_return !== retire_valid) begin
        $display("credit_return did not follow retire_valid at %0t", $time);
        mismatches++;
      end
      if (retire_valid) begin
        retired++;
        if (want_id.size() == 0) begin
          $display("Retire of id %h with no micro-op outstanding at %0t", retire_id, $time);
          mismatches++;
        end else begin
          compare("retire_id", 32'(retire_id), 32'(want_id.pop_front()));
          compare("retire_result", retire_result, want_result.pop_front());
          compare("store_retire", 32'(store_retire), 32'(want_store.pop_front()));
          compare("recover", 32'(recover), 32'(want_recover.pop_front()));
        end
      end
      if (in_valid) begin
        want_id.push_back(in_id);
        want_result.push_back(expected_result(in_op, in_src_a, in_src_b));
        want_store.push_back(in_op == OP_STORE);
        want_recover.push_back((in_op == OP_BRANCH) &&
                               ((in_src_a == in_src_b) != in_predict_taken));
      end
    end
  end

endmodule

// ==== retire_core_checker.sv ====
/*
  Retire core assertions
  Output consistency and quiet outputs after reset, bound into the core
*/
`timescale 1ns/1ns

module retire_core_checker (
  input logic clock,
  input logic reset,
  input logic retire_valid,
  input logic store_retire,
  input logic recover,
  input logic credit_return,
  input logic alu_done,
  input logic mul_done,
  input logic alu_start,
  input logic mul_start
);

  recover_with_retire: assert property (
    @(posedge clock) disable iff (reset) recover |-> retire_valid
  ) else $error("recover high without retire_valid");

  store_with_retire: assert property (
    @(posedge clock) disable iff (reset) store_retire |-> retire_valid
  ) else $error("store_retire high without retire_valid");

  quiet_after_reset: assert property (
    @(posedge clock) reset |=> !(retire_valid || store_retire || recover || credit_return ||
                                 alu_done || mul_done || alu_start || mul_start)
  ) else $error("output active in the cycle after reset");

endmodule

bind retire_core retire_core_checker checker0 (
  .clock         (clock),
  .reset         (reset),
  .retire_valid  (retire_valid),
  .store_retire  (store_retire),
  .recover       (recover),
  .credit_return (credit_return),
  .alu_done      (alu_done),
  .mul_done      (mul_done),
  .alu_start     (alu_start),
  .mul_start     (mul_start)
);

// ==== tb_retire_core.sv ====
/*
  Retire core testbench
  Sends a table of micro-ops under credit flow control and leaves the
  retire stream checks to the scoreboard
*/
`timescale 1ns/1ns

module tb_retire_core import exec_config_pkg::*; import uop_pkg::*; ();

  localparam int ROB_DEPTH   = ROB_DEPTH_DEFAULT;
  // Long multiply so that a burst behind it runs the sender out of credits
  localparam int MUL_LATENCY = 4 * MUL_LATENCY_DEFAULT;
  localparam int MAX_ROWS    = 64;
  localparam int WAIT_LIMIT  = 200;

  logic     clock;
  logic     reset;
  logic     in_valid;
  uop_id_t  in_id;
  op_kind_t in_op;
  data_t    in_src_a;
  data_t    in_src_b;
  logic     in_predict_taken;
  logic     credit_return;
  logic     retire_valid;
  uop_id_t  retire_id;
  data_t    retire_result;
  logic     store_retire;
  logic     recover;
  int       mismatches;
  int       retired;

  // Stimulus table indexed by micro-op id
  op_kind_t    row_op      [MAX_ROWS];
  data_t       row_a       [MAX_ROWS];
  data_t       row_b       [MAX_ROWS];
  logic        row_predict [MAX_ROWS];
  int          row_count;
  int          credits;
  int          stall_cycles;
  int          timeouts;
  logic [15:0] lfsr_state;

  retire_core #(.ROB_DEPTH(ROB_DEPTH), .MUL_LATENCY(MUL_LATENCY)) dut0 (.*);

  retire_scoreboard scoreboard0 (.*);

  initial clock = 1'b0;
  always #2 clock = ~clock;

  // Sender side credit count that recover refills
  always @(posedge clock) begin
    if (reset || recover) begin
      credits <= ROB_DEPTH;
    end else if (credit_return && !in_valid) begin
      credits <= credits + 1;
    end else if (in_valid && !credit_return) begin
      credits <= credits - 1;
    end
  end

  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] lfsr_bits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value      = {value[30:0], lfsr_state[0]};
    end
    return value;
  endfunction

  function automatic logic mispredicts(input int r);
    return (row_op[r] == OP_BRANCH) && ((row_a[r] == row_b[r]) != row_predict[r]);
  endfunction

  task automatic add_row(input op_kind_t op, input data_t a, input data_t b, input logic predict);
    row_op[row_count]      = op;
    row_a[row_count]       = a;
    row_b[row_count]       = b;
    row_predict[row_count] = predict;
    row_count++;
  endtask

  task automatic build_table();
    op_kind_t op;
    data_t    a;
    data_t    b;
    logic     predict;
    row_count = 0;
    add_row(OP_ADD, 32'd5, 32'd7, 1'b0);
    add_row(OP_SUB, 32'd3, 32'd5, 1'b0);
    add_row(OP_XOR, 32'hF0F0_1234, 32'h0FF0_4321, 1'b0);
    // Multiplies in flight while younger ALU rows finish first
    add_row(OP_MUL, 32'd1234, 32'd5678, 1'b0);
    add_row(OP_ADD, 32'hFFFF_FFFF, 32'd2, 1'b0);
    add_row(OP_MUL, 32'hDEAD_BEEF, 32'h0001_0003, 1'b0);
    add_row(OP_MUL, 32'h7FFF_FFFF, 32'h7FFF_FFFF, 1'b0);
    add_row(OP_SUB, 32'd10, 32'd4, 1'b0);
    add_row(OP_STORE, 32'h0000_1000, 32'h0000_0024, 1'b0);
    add_row(OP_STORE, 32'h8000_0000, 32'h8000_0010, 1'b0);
    // Two branches predicted right, then a mispredict and the row after it
    add_row(OP_BRANCH, 32'd9, 32'd9, 1'b1);
    add_row(OP_BRANCH, 32'd9, 32'd8, 1'b0);
    add_row(OP_BRANCH, 32'd4, 32'd4, 1'b0);
    add_row(OP_ADD, 32'd1, 32'd1, 1'b0);
    // Burst longer than the buffer stuck behind a multiply
    add_row(OP_MUL, 32'h1357_9BDF, 32'h2468_ACE0, 1'b0);
    for (int i = 0; i < 12; i++) begin
      add_row((i % 2 == 0) ? OP_ADD : OP_XOR, data_t'(i * 3), ~data_t'(i), 1'b0);
    end
    add_row(OP_BRANCH, 32'd1, 32'd2, 1'b1);
    for (int i = 0; i < 20; i++) begin
      op      = op_kind_t'(3'(lfsr_bits(3) % 6));
      a       = lfsr_bits(32);
      b       = lfsr_bits(32);
      predict = 1'(lfsr_bits(1));
      if (op == OP_BRANCH && 1'(lfsr_bits(1))) begin
        b = a;
      end
      add_row(op, a, b, predict);
    end
  endtask

  task automatic wait_for_credit();
    int waited;
    waited = 0;
    while (credits == 0 && waited < WAIT_LIMIT) begin
      @(negedge clock);
      waited++;
      stall_cycles++;
    end
    if (credits == 0) begin
      $display("Timeout: no credit came back within %0d cycles", WAIT_LIMIT);
      timeouts++;
    end
  endtask

  task automatic wait_for_recover();
    int waited;
    waited = 0;
    while (!recover && waited < WAIT_LIMIT) begin
      @(negedge clock);
      waited++;
    end
    if (recover) begin
      // Let the flush land before the next row goes in
      @(negedge clock);
    end else begin
      $display("Timeout: mispredicted branch never raised recover");
      timeouts++;
    end
  endtask

  task automatic wait_for_drain();
    int waited;
    waited = 0;
    while (retired < row_count && waited < WAIT_LIMIT) begin
      @(negedge clock);
      waited++;
    end
    if (retired < row_count) begin
      $display("Timeout: only %0d of %0d micro-ops retired", retired, row_count);
      timeouts++;
    end
  endtask

  initial begin
    reset            = 1'b1;
    in_valid         = 1'b0;
    in_id            = '0;
    in_op            = OP_ADD;
    in_src_a         = '0;
    in_src_b         = '0;
    in_predict_taken = 1'b0;
    timeouts         = 0;
    stall_cycles     = 0;
    lfsr_state       = 16'd27959;
    build_table();
    repeat (5) @(negedge clock);
    reset = 1'b0;
    for (int r = 0; r < row_count && timeouts == 0; r++) begin
      wait_for_credit();
      if (timeouts == 0) begin
        in_valid         = 1'b1;
        in_id            = uop_id_t'(r);
        in_op            = row_op[r];
        in_src_a         = row_a[r];
        in_src_b         = row_b[r];
        in_predict_taken = row_predict[r];
        @(negedge clock);
        in_valid = 1'b0;
        if (mispredicts(r)) begin
          wait_for_recover();
        end
      end
    end
    if (timeouts == 0) begin
      wait_for_drain();
    end
    if (timeouts == 0 && stall_cycles == 0) begin
      $display("The sender never ran out of credits so no burst was held back");
    end
    $display("Errors %0d, timeouts %0d, retired %0d of %0d, credit stall cycles %0d",
             mismatches, timeouts, retired, row_count, stall_cycles);
    if (mismatches == 0 && timeouts == 0 && stall_cycles != 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== retire_core.f ====
exec_config_pkg.sv
uop_pkg.sv
uop_intake.sv
alu_pipe.sv
mul_pipe.sv
reorder_buffer.sv
retire_core.sv
retire_scoreboard.sv
retire_core_checker.sv
tb_retire_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the retire core testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

log=sim.log

if ! verilator --binary --assert --top-module tb_retire_core -f retire_core.f; then
  echo "run_sim: build failed"
  exit 1
fi

./obj_dir/Vtb_retire_core > "$log" 2>&1
status=$?
cat "$log"

if [ "$status" -ne 0 ]; then
  echo "run_sim: simulation exited with status $status"
  exit 1
fi

if grep -q ">>> FAIL" "$log"; then
  exit 1
fi

if ! grep -q ">>> PASS" "$log"; then
  echo "run_sim: no verdict found in $log"
  exit 1
fi

exit 0
